// ==== design/ring_defines.svh ====
//------------------------------
// sizing for the ring switch
// NODE_ID_WIDTH must cover NODE_COUNT
// RING_FIFO_DEPTH of 2 or more, bubble rule needs two free entries
//------------------------------
`ifndef RING_DEFINES_SVH
`define RING_DEFINES_SVH

// ring size and node addressing
`define NODE_COUNT 7
`define NODE_ID_WIDTH 3

// flit fields
`define PAYLOAD_WIDTH 32
`define SEQ_WIDTH 8

// entries in each ring input buffer
`define RING_FIFO_DEPTH 4

// cycles a waiting injection yields before it wins over transit
`define INJECT_WAIT_LIMIT 8

`endif

// ==== design/ringPkg.sv ====
//------------------------------
// flit, link and grant types for the ring
// field widths follow ring_defines.svh
//------------------------------
`default_nettype none

`include "ring_defines.svh"

package ringPkg;

    // destination first, routers only look at this field
    typedef struct packed {
        logic [`NODE_ID_WIDTH-1:0] dest;
        logic [`NODE_ID_WIDTH-1:0] src;
        logic [`SEQ_WIDTH-1:0]     seq;
        logic [`PAYLOAD_WIDTH-1:0] payload;
    } flitT;

    // one link beat, ready travels beside it
    typedef struct packed {
        logic valid;
        flitT flit;
    } ringLinkT;

    typedef enum logic [1:0] {
        GRANT_NONE    = 2'd0,
        GRANT_TRANSIT = 2'd1,
        GRANT_INJECT  = 2'd2
    } grantT;

endpackage

`default_nettype wire

// ==== design/ringFifo.sv ====
//------------------------------
// ring input buffer, writer must respect slotAvail
// slot and bubble flags lag one edge behind pops
//------------------------------
`default_nettype none

`include "ring_defines.svh"

module ringFifo
    import ringPkg::*;
(
    input  wire           clk,
    input  wire           rst,
    input  wire ringLinkT wrLink,
    input  wire           rdEn,
    output ringLinkT      head,
    output logic          slotAvail,
    output logic          bubbleAvail
);

    localparam int Depth = `RING_FIFO_DEPTH;
    localparam int PtrWidth = $clog2(Depth);
    localparam int CntWidth = $clog2(Depth + 1);

    flitT mem [Depth];

    logic [PtrWidth-1:0] wrPtr;
    logic [PtrWidth-1:0] rdPtr;
    logic [CntWidth-1:0] count;

    // flit storage
    always_ff @(posedge clk) begin
        if (wrLink.valid) begin
            mem[wrPtr] <= wrLink.flit;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (wrLink.valid) begin
                wrPtr <= (wrPtr == PtrWidth'(Depth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (rdEn) begin
                rdPtr <= (rdPtr == PtrWidth'(Depth - 1)) ? '0 : rdPtr + 1'b1;
            end
            case ({wrLink.valid, rdEn})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head = '{valid: count != '0, flit: mem[rdPtr]};

    // one free entry takes a transit flit, two are needed to inject
    assign slotAvail = count < CntWidth'(Depth);
    assign bubbleAvail = count <= CntWidth'(Depth - 2);

    // upstream link register must wait for a free slot
    noWriteWhenFull: assert property (
        @(posedge clk) disable iff (rst)
        wrLink.valid |-> count != CntWidth'(Depth)
    ) else $error("ring buffer written while full");

    noReadWhenEmpty: assert property (
        @(posedge clk) disable iff (rst)
        rdEn |-> count != '0
    ) else $error("ring buffer popped while empty");

endmodule

`default_nettype wire

// ==== design/ringLinkArbiter.sv ====
//------------------------------
// shares one outgoing ring link
// transit first, injection needs a bubble downstream
// a starved injection wins after INJECT_WAIT_LIMIT cycles
//------------------------------
`default_nettype none

`include "ring_defines.svh"

module ringLinkArbiter
    import ringPkg::*;
(
    input  wire           clk,
    input  wire           rst,
    input  wire ringLinkT transit,
    input  wire ringLinkT inject,
    input  wire           slotAvail,
    input  wire           bubbleAvail,
    output logic          transitTaken,
    output logic          injectReady,
    output ringLinkT      ringOut
);

    localparam int WaitWidth = $clog2(`INJECT_WAIT_LIMIT + 1);
    localparam logic [WaitWidth-1:0] WaitMax = WaitWidth'(`INJECT_WAIT_LIMIT);

    logic                 linkValid;
    flitT                 linkFlit;
    logic [WaitWidth-1:0] waitCnt;
    logic                 canLoad;
    logic                 injectStarved;
    grantT                grant;

    // link register is empty or hands its flit on at this edge
    assign canLoad = !linkValid || slotAvail;
    assign injectStarved = waitCnt == WaitMax;

    // ready does not look at inject.valid
    assign injectReady = canLoad && bubbleAvail && (!transit.valid || injectStarved);

    always_comb begin
        grant = GRANT_NONE;
        if (inject.valid && injectReady) begin
            grant = GRANT_INJECT;
        end else if (transit.valid && canLoad) begin
            grant = GRANT_TRANSIT;
        end
    end

    assign transitTaken = grant == GRANT_TRANSIT;

    always_ff @(posedge clk) begin
        if (rst) begin
            linkValid <= 1'b0;
        end else if (grant != GRANT_NONE) begin
            linkValid <= 1'b1;
        end else if (slotAvail) begin
            linkValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        case (grant)
            GRANT_TRANSIT: linkFlit <= transit.flit;
            GRANT_INJECT: linkFlit <= inject.flit;
            default: linkFlit <= linkFlit;
        endcase
    end

    // saturating count of cycles an offered flit went unserved
    always_ff @(posedge clk) begin
        if (rst) begin
            waitCnt <= '0;
        end else if (grant == GRANT_INJECT || !inject.valid) begin
            waitCnt <= '0;
        end else if (!injectStarved) begin
            waitCnt <= waitCnt + 1'b1;
        end
    end

    assign ringOut = '{valid: linkValid, flit: linkFlit};

    injectNeedsBubble: assert property (
        @(posedge clk) disable iff (rst)
        (grant == GRANT_INJECT) |-> bubbleAvail
    ) else $error("injection granted without two free slots downstream");

endmodule

`default_nettype wire

// ==== design/ringRouter.sv ====
//------------------------------
// one ring node, ejects flits addressed to NodeId
// everything else goes on to the next node
// inject must never name this node as destination
//------------------------------
`default_nettype none

`include "ring_defines.svh"

module ringRouter
    import ringPkg::*;
#(
    parameter int NodeId = 0
) (
    input  wire           clk,
    input  wire           rst,
    input  wire ringLinkT ringIn,
    output logic          slotAvail,
    output logic          bubbleAvail,
    output ringLinkT      ringOut,
    input  wire           nextSlotAvail,
    input  wire           nextBubbleAvail,
    input  wire ringLinkT inject,
    output logic          injectReady,
    output ringLinkT      eject,
    input  wire           ejectReady
);

    localparam logic [`NODE_ID_WIDTH-1:0] LocalId = NodeId[`NODE_ID_WIDTH-1:0];

    ringLinkT fifoWr;
    ringLinkT head;
    ringLinkT transit;
    logic     isLocal;
    logic     transitTaken;
    logic     headPop;

    // accept from upstream only while a slot is free
    assign fifoWr = '{valid: ringIn.valid && slotAvail, flit: ringIn.flit};

    ringFifo uFifo (
        .clk(clk),
        .rst(rst),
        .wrLink(fifoWr),
        .rdEn(headPop),
        .head(head),
        .slotAvail(slotAvail),
        .bubbleAvail(bubbleAvail)
    );

    // destination decode on the buffer head
    assign isLocal = head.flit.dest == LocalId;

    assign eject = '{valid: head.valid && isLocal, flit: head.flit};
    assign transit = '{valid: head.valid && !isLocal, flit: head.flit};

    assign headPop = (eject.valid && ejectReady) || transitTaken;

    ringLinkArbiter uArbiter (
        .clk(clk),
        .rst(rst),
        .transit(transit),
        .inject(inject),
        .slotAvail(nextSlotAvail),
        .bubbleAvail(nextBubbleAvail),
        .transitTaken(transitTaken),
        .injectReady(injectReady),
        .ringOut(ringOut)
    );

    // a self-addressed flit would circle the ring for good
    injectNotLocal: assert property (
        @(posedge clk) disable iff (rst)
        inject.valid |-> inject.flit.dest != LocalId
    ) else $error("flit injected at node %0d addressed to itself", NodeId);

    ejectHeld: assert property (
        @(posedge clk) disable iff (rst)
        (eject.valid && !ejectReady) |=> eject.valid && $stable(eject.flit)
    ) else $error("eject flit changed under back-pressure at node %0d", NodeId);

endmodule

`default_nettype wire

// ==== design/ringSwitch.sv ====
//------------------------------
// seven nodes on a clockwise ring
// node i feeds node i+1, the last wraps to node 0
//------------------------------
`default_nettype none

`include "ring_defines.svh"

module ringSwitch
    import ringPkg::*;
(
    input  wire                      clk,
    input  wire                      rst,
    input  wire ringLinkT            inject [`NODE_COUNT],
    output logic [`NODE_COUNT-1:0]   injectReady,
    output ringLinkT                 eject [`NODE_COUNT],
    input  wire [`NODE_COUNT-1:0]    ejectReady
);

    // ringLink[i] leaves node i, slotAvail[i] comes back from node i
    wire ringLinkT               ringLink [`NODE_COUNT];
    wire [`NODE_COUNT-1:0]       slotAvail;
    wire [`NODE_COUNT-1:0]       bubbleAvail;

    for (genvar i = 0; i < `NODE_COUNT; i++) begin : gNode
        localparam int Prev = (i + `NODE_COUNT - 1) % `NODE_COUNT;
        localparam int Next = (i + 1) % `NODE_COUNT;

        ringRouter #(
            .NodeId(i)
        ) uRouter (
            .clk(clk),
            .rst(rst),
            .ringIn(ringLink[Prev]),
            .slotAvail(slotAvail[i]),
            .bubbleAvail(bubbleAvail[i]),
            .ringOut(ringLink[i]),
            .nextSlotAvail(slotAvail[Next]),
            .nextBubbleAvail(bubbleAvail[Next]),
            .inject(inject[i]),
            .injectReady(injectReady[i]),
            .eject(eject[i]),
            .ejectReady(ejectReady[i])
        );
    end

endmodule

`default_nettype wire

// ==== testbench/tbRingSwitch.sv ====
//------------------------------
// random traffic through the ring switch, one expected queue per pair
// outputs sampled at the falling edge, inputs driven at the rising edge
// drain after each test is bounded by DrainLimit cycles
//------------------------------
`default_nettype none

`include "ring_defines.svh"

module tbRingSwitch
    import ringPkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int PairCount = `NODE_COUNT * `NODE_COUNT;
    localparam int DrainLimit = 2000;

    logic                   clk = 1'b0;
    logic                   rst;
    ringLinkT               inject [`NODE_COUNT];
    logic [`NODE_COUNT-1:0] injectReady;
    ringLinkT               eject [`NODE_COUNT];
    logic [`NODE_COUNT-1:0] ejectReady;

    // reference model, indexed by src * NODE_COUNT + dest
    flitT                   expQ [PairCount][$];
    logic [`SEQ_WIDTH-1:0]  seqCnt [PairCount];

    // eject flit seen under back-pressure at the last sample
    logic                   held [`NODE_COUNT];
    flitT                   heldFlit [`NODE_COUNT];

    integer seed = 87239;
    int     injected;
    int     ejected;
    int     errors;
    bit     timedOut;

    always #50 clk = ~clk;

    ringSwitch u_dut (
        .clk(clk),
        .rst(rst),
        .inject(inject),
        .injectReady(injectReady),
        .eject(eject),
        .ejectReady(ejectReady)
    );

    function automatic int roll();
        return int'($unsigned($random(seed)) % 100);
    endfunction

    // any destination but the source itself
    function automatic flitT newFlit(input int src);
        flitT f;
        int   dest;
        int   pair;
        dest = (src + 1 + int'($unsigned($random(seed)) % (`NODE_COUNT - 1))) % `NODE_COUNT;
        pair = src * `NODE_COUNT + dest;
        f.dest = `NODE_ID_WIDTH'(dest);
        f.src = `NODE_ID_WIDTH'(src);
        f.seq = seqCnt[pair];
        f.payload = $random(seed);
        seqCnt[pair] = seqCnt[pair] + 1'b1;
        return f;
    endfunction

    function automatic bit injectPending();
        bit pending;
        pending = 1'b0;
        for (int i = 0; i < `NODE_COUNT; i++) begin
            pending = pending | inject[i].valid;
        end
        return pending;
    endfunction

    task automatic recordInject(input flitT f);
        expQ[int'(f.src) * `NODE_COUNT + int'(f.dest)].push_back(f);
        injected++;
    endtask

    task automatic checkEject(input int node, input flitT f);
        int   idx;
        flitT want;
        ejected++;
        assert (int'(f.dest) == node) else begin
            $display("CHECK FAILED at %0t: eject[%0d].dest expected %0d got %0d",
                     $time, node, node, f.dest);
            errors++;
        end
        assert (int'(f.src) < `NODE_COUNT) else begin
            $display("node %0d ejected a flit whose source ID %0d names no node", node, f.src);
            errors++;
        end
        if (int'(f.src) < `NODE_COUNT && int'(f.dest) == node) begin
            idx = int'(f.src) * `NODE_COUNT + node;
            assert (expQ[idx].size() != 0) else begin
                $display("node %0d ejected a flit from node %0d that was never injected",
                         node, f.src);
                errors++;
            end
            if (expQ[idx].size() != 0) begin
                want = expQ[idx].pop_front();
                assert (f.seq == want.seq) else begin
                    $display("CHECK FAILED at %0t: eject[%0d].seq expected %0d got %0d",
                             $time, node, want.seq, f.seq);
                    errors++;
                end
                assert (f.payload == want.payload) else begin
                    $display("CHECK FAILED at %0t: eject[%0d].payload expected %h got %h",
                             $time, node, want.payload, f.payload);
                    errors++;
                end
            end
        end
    endtask

    // a flit refused by ejectReady must still be there one cycle later
    task automatic checkHold(input int node);
        if (held[node]) begin
            assert (eject[node].valid) else begin
                $display("eject valid at node %0d dropped before its flit was accepted", node);
                errors++;
            end
            assert (eject[node].flit == heldFlit[node]) else begin
                $display("CHECK FAILED at %0t: eject[%0d].flit expected %h got %h",
                         $time, node, heldFlit[node], eject[node].flit);
                errors++;
            end
        end
        held[node] = eject[node].valid && !ejectReady[node];
        heldFlit[node] = eject[node].flit;
    endtask

    task automatic runCycle(input int injPct, input int rdyPct);
        bit taken [`NODE_COUNT];
        @(negedge clk);
        for (int i = 0; i < `NODE_COUNT; i++) begin
            checkHold(i);
            taken[i] = inject[i].valid && injectReady[i];
            if (taken[i]) begin
                recordInject(inject[i].flit);
            end
            if (eject[i].valid && ejectReady[i]) begin
                checkEject(i, eject[i].flit);
            end
        end
        @(posedge clk);
        for (int i = 0; i < `NODE_COUNT; i++) begin
            // an offered flit stays put until the node takes it
            if (taken[i] || !inject[i].valid) begin
                if (roll() < injPct) begin
                    inject[i] <= '{valid: 1'b1, flit: newFlit(i)};
                end else begin
                    inject[i] <= '0;
                end
            end
            ejectReady[i] <= roll() < rdyPct;
        end
    endtask

    task automatic checkReset();
        int err0;
        err0 = errors;
        @(negedge clk);
        for (int i = 0; i < `NODE_COUNT; i++) begin
            assert (!eject[i].valid) else begin
                $display("CHECK FAILED at %0t: eject[%0d].valid expected 0 got %0b",
                         $time, i, eject[i].valid);
                errors++;
            end
            assert (injectReady[i]) else begin
                $display("CHECK FAILED at %0t: injectReady[%0d] expected 1 got %0b",
                         $time, i, injectReady[i]);
                errors++;
            end
        end
        $display("test %-13s errors %0d", "reset", errors - err0);
    endtask

    task automatic trafficTest(input string name, input int cycles, input int injPct,
                               input int rdyPct);
        int inj0;
        int ej0;
        int err0;
        int waited;
        inj0 = injected;
        ej0 = ejected;
        err0 = errors;
        for (int c = 0; c < cycles; c++) begin
            runCycle(injPct, rdyPct);
        end
        // stop offering new flits and let the ring empty
        waited = 0;
        while ((injected != ejected || injectPending()) && waited < DrainLimit) begin
            runCycle(0, rdyPct);
            waited++;
        end
        assert (injected == ejected && !injectPending()) else begin
            $display("ring did not drain within %0d cycles after test %s", DrainLimit, name);
            errors++;
            timedOut = 1'b1;
        end
        $display("test %-13s injected %4d  ejected %4d  errors %0d",
                 name, injected - inj0, ejected - ej0, errors - err0);
    endtask

    task automatic checkQueuesEmpty();
        for (int p = 0; p < PairCount; p++) begin
            assert (expQ[p].size() == 0) else begin
                $display("%0d flits from node %0d to node %0d were never ejected",
                         expQ[p].size(), p / `NODE_COUNT, p % `NODE_COUNT);
                errors++;
            end
        end
        assert (ejected == injected) else begin
            $display("CHECK FAILED at %0t: ejected count expected %0d got %0d",
                     $time, injected, ejected);
            errors++;
        end
    endtask

    initial begin
        rst = 1'b1;
        ejectReady = '0;
        for (int i = 0; i < `NODE_COUNT; i++) begin
            inject[i] = '0;
            held[i] = 1'b0;
            heldFlit[i] = '0;
        end
        for (int p = 0; p < PairCount; p++) begin
            seqCnt[p] = '0;
        end
        injected = 0;
        ejected = 0;
        errors = 0;
        timedOut = 1'b0;

        repeat (2) @(posedge clk);
        rst <= 1'b0;

        checkReset();
        if (!timedOut) begin
            trafficTest("delivery", 400, 30, 80);
        end
        if (!timedOut) begin
            trafficTest("back-pressure", 400, 30, 25);
        end
        if (!timedOut) begin
            trafficTest("heavy-load", 600, 100, 50);
        end
        checkQueuesEmpty();

        $display("total injected %0d, ejected %0d, errors %0d", injected, ejected, errors);
        if (errors == 0 && !timedOut) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+design
design/ringPkg.sv
design/ringFifo.sv
design/ringLinkArbiter.sv
design/ringRouter.sv
design/ringSwitch.sv
testbench/tbRingSwitch.sv

// ==== run.sh ====
#!/bin/sh
# build the ring switch testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sim.f --top-module tbRingSwitch \
    --Mdir obj_dir -o simRing || exit 1
simOut=$(./obj_dir/simRing)
printf '%s\n' "$simOut"
printf '%s\n' "$simOut" | grep -q "TEST PASSED" && exit 0 || exit 1
